//--- vlog.f
+incdir+tb
hdl/cpu8_pkg.sv
hdl/cpu8_alu.sv
hdl/cpu8.sv
hdl/cpu8_mem.sv
hdl/cpu8_sys.sv
tb/tb_cpu8_sys.sv

//--- Makefile
TOP := tb_cpu8_sys

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir

//--- tb/cpu8_isa_model.svh
// cpu8 ISA model and program generator

// --------------------
// encodings, register index added in the low bits
localparam logic [7:0] I_LDI   = 8'h60;  // immediate follows
localparam logic [7:0] I_LDM   = 8'h64;
localparam logic [7:0] I_STM   = 8'h68;
localparam logic [7:0] I_JC    = 8'h40;  // no immediate
localparam logic [7:0] I_JMP   = 8'h44;
localparam logic [7:0] I_JR    = 8'h48;
localparam logic [7:0] I_CALL  = 8'h4C;
localparam logic [7:0] I_NOT   = 8'h50;
localparam logic [7:0] I_LNOT  = 8'h54;
localparam logic [7:0] I_PUSH  = 8'h58;
localparam logic [7:0] I_POP   = 8'h5C;
localparam logic [7:0] I_HALT  = 8'h00;
localparam logic [7:0] I_RET   = 8'h02;
localparam logic [7:0] I_CMP12 = 8'hD6;  // cmp r1, r2
localparam logic [7:0] SUB_AT  = 8'h80;  // subroutine start

integer     seed = 32'hb559;
logic [7:0] img [256];        // image for the load port
logic [7:0] mm [256];         // model memory
logic [7:0] exp_addr [$];     // expected write trace
logic [7:0] exp_data [$];
logic [7:0] exp_instr;        // opcode that stops the run
int         gen_pos;          // next program word
logic [7:0] st_ptr;           // next data cell
int         sel_turn = 0;     // select op rotation

function automatic logic [7:0] rnd8();
  rnd8 = 8'($random(seed));
endfunction

task automatic emit(input logic [7:0] w);
  img[gen_pos] = w;
  gen_pos = gen_pos + 1;
endtask

task automatic emit2(input logic [7:0] w, input logic [7:0] v);
  emit(w);
  emit(v);
endtask

task automatic store(input logic [1:0] r);  // stm to the next data cell
  emit2(I_STM | {6'b0, r}, st_ptr);
  st_ptr = st_ptr + 8'd1;
endtask

// --------------------
// program generator, forward jumps only
task automatic gen_program(input int kind);
  logic [7:0] a;
  logic [7:0] v;
  logic [1:0] x;
  logic [1:0] y;
  logic [1:0] d;
  int         i;
  for (i = 0; i < 256; i++) begin
    img[i] = 8'h00;                 // zero data, halt past the code
  end
  gen_pos = 0;
  st_ptr  = 8'hC0;
  emit2(I_LDI, 8'hFF);              // sp
  case (kind)
    0: begin
      emit2(I_LDI | 8'd1, rnd8());
      emit2(I_LDI | 8'd2, rnd8());
      for (i = 0; i < 5; i++) begin
        a = rnd8();
        x = a[0] ? 2'd2 : 2'd1;
        y = a[1] ? 2'd2 : 2'd1;
        v = rnd8();
        if (a[6]) v = v & 8'h07;   // small shift counts now and then
        emit2(I_LDI | (a[5] ? 8'd2 : 8'd1), v);
        emit({1'b1, a[4:2], x, y});
        d = (a[4:2] == 3'd0) ? y : (a[4:2] == 3'd5) ? 2'd3 : x;  // mov, cmp, rest
        store(d);
      end
      emit(I_HALT);
    end
    1: begin
      for (i = 0; i < 3; i++) begin
        a = rnd8();
        v = rnd8();
        if (v[1:0] == 2'b00) v = a;  // equal operands sometimes
        emit2(I_LDI | 8'd1, a);
        emit2(I_LDI | 8'd2, v);
        emit(I_CMP12);
        v = 8'(sel_turn % 6);        // none, then sne..sle in turn
        sel_turn = sel_turn + 1;
        if (v != 8'd0) emit(8'h03 + v);  // sne..sle, none keeps eq
        emit2(I_LDI | 8'd1, 8'(gen_pos + 5));
        emit(I_JC | 8'd1);
        store(2'd2);                 // skipped when bit 0 set
      end
      emit(I_HALT);
    end
    2: begin
      emit2(I_LDI | 8'd1, rnd8());
      emit2(I_LDI | 8'd2, rnd8());
      emit(I_PUSH | 8'd1);
      emit(I_PUSH | 8'd2);
      emit(I_POP | 8'd1);            // swapped
      emit(I_POP | 8'd2);
      store(2'd1);
      store(2'd2);
      for (i = 0; i < 2; i++) begin
        emit2(I_LDI | 8'd1, SUB_AT);
        emit(I_CALL | 8'd1);
        store(2'd1);
        store(2'd2);
      end
      emit(I_HALT);
      gen_pos = int'(SUB_AT);
      a = rnd8();
      emit(I_PUSH | 8'd2);
      emit({1'b1, a[2:0], a[4] ? 2'd2 : 2'd1, a[5] ? 2'd2 : 2'd1});
      emit(a[3] ? (I_NOT | 8'd2) : (I_LNOT | 8'd2));
      emit(I_POP | 8'd1);
      emit(I_RET);
    end
    3: begin
      for (i = 0; i < 4; i++) begin
        emit2(I_LDI | 8'd1, rnd8());
        store(2'd1);                 // cells c0..c3
      end
      st_ptr = 8'hC8;
      for (i = 0; i < 4; i++) begin
        a = rnd8() % 8'd5;           // c4 stays zero
        emit2(I_LDM | 8'd2, 8'hC0 + a);
        store(2'd2);
      end
      emit(I_HALT);
    end
    default: begin
      emit2(I_LDI | 8'd2, rnd8());
      store(2'd2);
      emit2(I_LDI | 8'd1, 8'd2);
      emit(I_JR | 8'd1);
      store(2'd2);                   // jumped over
      emit2(I_LDI | 8'd1, 8'(gen_pos + 5));
      emit(I_JMP | 8'd1);
      store(2'd2);                   // jumped over
      store(2'd2);
      a = rnd8();
      case (a[1:0])
        2'd0: emit(I_HALT);
        2'd1: emit(8'h09 + (a >> 3) % 8'd23);  // zero-reg gaps
        2'd2: emit(8'h20 | (a >> 2));          // zero-reg with imm
        default: emit(8'h6C + (a >> 3) % 8'd20);  // one-reg imm gaps
      endcase
      emit2(I_LDI | 8'd1, rnd8());
      store(2'd1);                   // never reached
    end
  endcase
endtask

task automatic write_cell(input logic [7:0] addr, input logic [7:0] data);
  mm[addr] = data;
  exp_addr.push_back(addr);
  exp_data.push_back(data);
endtask

// --------------------
// ISA-level execution of the image
task automatic run_model();
  logic [7:0] r [4];
  logic [7:0] pc;
  logic [7:0] w;
  logic [7:0] imm;
  logic [7:0] a;
  logic [7:0] b;
  logic [7:0] t;
  bit         stop;
  int         steps;
  mm = img;
  exp_addr.delete();
  exp_data.delete();
  r = '{default: 8'h00};
  pc = 8'h00;
  stop = 1'b0;
  steps = 0;
  while (!stop && steps < 256) begin
    w = mm[pc];
    pc = pc + 8'd1;
    steps++;
    if (w[7]) begin                  // two-register
      a = r[w[3:2]];
      b = r[w[1:0]];
      case (w[6:4])
        3'd0: r[w[1:0]] = a;         // mov into bb
        3'd1: r[w[3:2]] = a + b;
        3'd2: r[w[3:2]] = a - b;
        3'd3: r[w[3:2]] = a << b;
        3'd4: r[w[3:2]] = a >> b;
        3'd5: r[3] = {2'b00, a <= b, a < b, a >= b, a > b, a != b, a == b};
        3'd6: r[w[3:2]] = a & b;
        default: r[w[3:2]] = a | b;
      endcase
    end else if (w[7:6] == 2'b01 && w[5]) begin
      imm = mm[pc];
      pc = pc + 8'd1;
      case (w[4:2])
        3'd0: r[w[1:0]] = imm;
        3'd1: r[w[1:0]] = mm[imm];
        3'd2: write_cell(imm, r[w[1:0]]);
        default: stop = 1'b1;
      endcase
    end else if (w[7:6] == 2'b01) begin
      t = r[w[1:0]];
      case (w[4:2])
        3'd0: if (r[3][0]) pc = t;
        3'd1: pc = t;
        3'd2: pc = pc + t;
        3'd3: begin                  // call
          r[0] = r[0] - 8'd1;
          write_cell(r[0], pc);
          pc = t;
        end
        3'd4: r[w[1:0]] = ~t;
        3'd5: r[w[1:0]] = (t == 8'd0) ? 8'd1 : 8'd0;
        3'd6: begin                  // push
          r[0] = r[0] - 8'd1;
          write_cell(r[0], t);
        end
        default: begin               // pop
          t = mm[r[0]];
          r[0] = r[0] + 8'd1;
          r[w[1:0]] = t;
        end
      endcase
    end else begin
      case (w[5:0])
        6'd1: stop = 1'b0;           // nop
        6'd2: begin
          pc = mm[r[0]];
          r[0] = r[0] + 8'd1;
        end
        6'd4: r[3][0] = r[3][1];     // ne
        6'd5: r[3][0] = r[3][2];     // gt
        6'd6: r[3][0] = r[3][3];     // ge
        6'd7: r[3][0] = r[3][4];     // lt
        6'd8: r[3][0] = r[3][5];     // le
        default: stop = 1'b1;        // halt and unknown
      endcase
    end
  end
  exp_instr = w;                     // last word fetched
endtask

//--- tb/tb_cpu8_sys.sv
// cpu8 system testbench
`timescale 1ns/1ps

module tb_cpu8_sys;
  import cpu8_pkg::*;

  localparam int NUM_TESTS = 10;
  localparam int MAX_PROG  = 40;                         // words per program
  localparam int LIMIT     = NUM_TESTS * MAX_PROG * 12;  // cycles out of reset

  logic  in_clk    = 1'b0;
  logic  in_rst    = 1'b1;
  logic  load_en   = 1'b0;
  addr_t load_addr = '0;
  word_t load_data = '0;
  logic  wr_valid;
  addr_t wr_addr;
  word_t wr_data;
  logic  halted;
  word_t instr;

  int run_cycles = 0;
  int wr_seen    = 0;   // writes in this test
  int mon_errors = 0;   // from the write monitor
  int errors     = 0;   // from the test sequence

  `include "cpu8_isa_model.svh"

  cpu8_sys #(
    .ENTRY_ADDR  (8'h00),
    .WAIT_STATES (1)
  ) i_dut (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .wr_valid  (wr_valid),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .halted    (halted),
    .instr     (instr)
  );

  always #2 in_clk = ~in_clk;

  // --------------------
  // run limit
  always @(posedge in_clk) begin
    if (!in_rst) begin
      run_cycles <= run_cycles + 1;  // load time not counted
    end
  end

  initial begin
    while (run_cycles < LIMIT) begin
      @(posedge in_clk);
    end
    $display("timeout after %0d cycles out of reset, core never halted", run_cycles);
    $display(">>> FAIL");
    $finish;
  end

  // --------------------
  // write trace against the model
  always @(negedge in_clk) begin
    if (in_rst) begin
      wr_seen = 0;
    end else if (wr_valid) begin
      assert (!halted) else begin
        $display("write to %h seen while the core is halted", wr_addr);
        mon_errors = mon_errors + 1;
      end
      if (wr_seen < exp_addr.size()) begin
        assert (wr_addr == exp_addr[wr_seen]) else begin
          $display("FAILED %0t wr_addr got %h expected %h", $time, wr_addr, exp_addr[wr_seen]);
          mon_errors = mon_errors + 1;
        end
        assert (wr_data == exp_data[wr_seen]) else begin
          $display("FAILED %0t wr_data got %h expected %h", $time, wr_data, exp_data[wr_seen]);
          mon_errors = mon_errors + 1;
        end
      end
      wr_seen = wr_seen + 1;         // extras counted at the end
    end
  end

  function automatic string kind_name(input int kind);
    case (kind)
      0: return "alu";
      1: return "compare";
      2: return "stack";
      3: return "load";
      default: return "halt";
    endcase
  endfunction

  // image in under reset, then 3 more reset cycles
  task automatic load_program();
    int i;
    @(posedge in_clk);
    in_rst <= 1'b1;
    for (i = 0; i < 256; i++) begin
      @(posedge in_clk);
      load_en   <= 1'b1;
      load_addr <= addr_t'(i);
      load_data <= img[i];
    end
    @(posedge in_clk);
    load_en <= 1'b0;
    repeat (3) @(posedge in_clk);
    in_rst <= 1'b0;
  endtask

  // --------------------
  // test sequence
  initial begin
    int t;
    int kind;
    int err_start;
    int failed_tests;
    failed_tests = 0;
    for (t = 0; t < NUM_TESTS; t++) begin
      kind      = t % 5;
      err_start = errors + mon_errors;
      gen_program(kind);
      run_model();
      load_program();
      @(negedge in_clk);
      assert (!halted && !wr_valid) else begin
        $display("test %0d: halted or wr_valid high right after reset", t);
        errors = errors + 1;
      end
      while (!halted) begin
        @(negedge in_clk);           // bounded by the run limit
      end
      repeat (8) @(negedge in_clk);  // quiet window after halt
      assert (halted) else begin
        $display("test %0d: core left halt without a reset", t);
        errors = errors + 1;
      end
      assert (instr == exp_instr) else begin
        $display("FAILED %0t instr got %h expected %h", $time, instr, exp_instr);
        errors = errors + 1;
      end
      assert (wr_seen == exp_addr.size()) else begin
        if (wr_seen < exp_addr.size()) begin
          $display("test %0d: %0d write(s) missing, model made %0d", t,
                   exp_addr.size() - wr_seen, exp_addr.size());
        end else begin
          $display("test %0d: %0d extra write(s), model made %0d", t,
                   wr_seen - exp_addr.size(), exp_addr.size());
        end
        errors = errors + 1;
      end
      if (errors + mon_errors == err_start) begin
        $display("test %0d %s: ok, %0d writes", t, kind_name(kind), wr_seen);
      end else begin
        failed_tests = failed_tests + 1;
        $display("test %0d %s: failed, %0d errors", t, kind_name(kind),
                 errors + mon_errors - err_start);
      end
    end
    $display("tests %0d, failed %0d, errors %0d, cycles %0d", NUM_TESTS, failed_tests,
             errors + mon_errors, run_cycles);
    if (errors + mon_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- hdl/cpu8_sys.sv
// cpu8 system top
`timescale 1ns/1ps

module cpu8_sys #(
  parameter cpu8_pkg::addr_t ENTRY_ADDR  = 8'h00,  // program start
  parameter int              WAIT_STATES = 1       // memory latency
) (
  input  logic            in_clk,
  input  logic            in_rst,
  input  logic            load_en,     // program load, under reset only
  input  cpu8_pkg::addr_t load_addr,
  input  cpu8_pkg::word_t load_data,
  output logic            wr_valid,
  output cpu8_pkg::addr_t wr_addr,
  output cpu8_pkg::word_t wr_data,
  output logic            halted,
  output cpu8_pkg::word_t instr
);
  import cpu8_pkg::*;

  // core to memory bus
  logic  mem_req;
  logic  mem_write;
  logic  mem_ack;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;

  cpu8 #(
    .ENTRY_ADDR (ENTRY_ADDR)
  ) i_cpu (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .instr     (instr),
    .halted    (halted)
  );

  cpu8_mem #(
    .WAIT_STATES (WAIT_STATES)
  ) i_mem (
    .in_clk    (in_clk),
    .in_rst    (in_rst),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .wr_valid  (wr_valid),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

endmodule

//--- hdl/cpu8_mem.sv
// cpu8 wait-state memory
`timescale 1ns/1ps

module cpu8_mem #(
  parameter int WAIT_STATES = 1  // cycles before acknowledge
) (
  input  logic            in_clk,
  input  logic            in_rst,
  input  logic            mem_req,
  input  logic            mem_write,
  input  cpu8_pkg::addr_t mem_addr,
  input  cpu8_pkg::word_t mem_wdata,
  output logic            mem_ack,
  output cpu8_pkg::word_t mem_rdata,
  input  logic            load_en,
  input  cpu8_pkg::addr_t load_addr,
  input  cpu8_pkg::word_t load_data,
  output logic            wr_valid,    // one pulse per committed write
  output cpu8_pkg::addr_t wr_addr,
  output cpu8_pkg::word_t wr_data
);
  import cpu8_pkg::*;

  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  word_t            mem [256];
  logic             busy;      // request latched
  logic [CNT_W-1:0] cnt;       // wait states left
  addr_t            addr_q;
  word_t            wdata_q;
  logic             write_q;

  assign mem_ack   = busy && (cnt == '0);
  assign mem_rdata = mem[addr_q];  // valid with the acknowledge

  // --------------------
  // request tracking
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      busy     <= 1'b0;
      cnt      <= '0;
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= mem_ack && write_q;
      if (!busy) begin
        busy <= mem_req;              // accept only when idle
        cnt  <= CNT_W'(WAIT_STATES);
      end else if (mem_ack) begin
        busy <= 1'b0;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (!busy && mem_req) begin
      addr_q  <= mem_addr;
      wdata_q <= mem_wdata;
      write_q <= mem_write;
    end
    if (mem_ack) begin
      wr_addr <= addr_q;              // monitor copy of the commit
      wr_data <= wdata_q;
    end
  end

  // --------------------
  // array port, load first
  always_ff @(posedge in_clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end else if (mem_ack && write_q) begin
      mem[addr_q] <= wdata_q;         // commit on the ack edge
    end
  end

  a_ack_single: assert property (@(posedge in_clk) disable iff (in_rst)
    mem_ack |=> !mem_ack);

endmodule

//--- hdl/cpu8.sv
// cpu8 multi-cycle core
`timescale 1ns/1ps

module cpu8 #(
  parameter cpu8_pkg::addr_t ENTRY_ADDR = 8'h00  // pc after reset
) (
  input  logic            in_clk,
  input  logic            in_rst,
  input  logic            mem_ack,
  input  cpu8_pkg::word_t mem_rdata,
  output logic            mem_req,
  output logic            mem_write,
  output cpu8_pkg::addr_t mem_addr,
  output cpu8_pkg::word_t mem_wdata,
  output cpu8_pkg::word_t instr,      // current instruction
  output logic            halted
);
  import cpu8_pkg::*;

  cycle_t     cycle, next_cycle;
  logic       sub, next_sub;          // subcycle, 0 issue and 1 wait
  word_t      next_instr;
  logic       next_mem_req;
  logic       next_mem_write;
  addr_t      next_mem_addr;
  word_t      next_mem_wdata;
  addr_t      pc, next_pc;
  word_t      regs [4];
  word_t      next_regs [4];
  reg_idx_t   ra, next_ra;            // aa field
  reg_idx_t   rb, next_rb;            // bb field
  word_t      imm, next_imm;          // immediate word
  logic       rd_issue;               // exec op starts a memory read
  alu_op_t    alu_op;
  word_t      alu_result;
  word_t      alu_flags;
  logic [2:0] flag_sel;               // status bit for a select op

  assign alu_op   = alu_op_t'(instr[6:4]);
  assign flag_sel = 3'(instr[3:0] - 4'd3);  // sne..sle -> flag bits 1..5
  assign halted   = (cycle == HALT);

  cpu8_alu i_alu (
    .op     (alu_op),
    .a      (regs[ra]),
    .b      (regs[rb]),
    .result (alu_result),
    .flags  (alu_flags)
  );

  // --------------------
  // state registers
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      cycle     <= FETCH;
      sub       <= 1'b0;
      pc        <= ENTRY_ADDR;
      instr     <= '0;
      mem_req   <= 1'b0;
      mem_write <= 1'b0;
      regs      <= '{default: '0};
    end else begin
      cycle     <= next_cycle;
      sub       <= next_sub;
      pc        <= next_pc;
      instr     <= next_instr;
      mem_req   <= next_mem_req;
      mem_write <= next_mem_write;
      regs      <= next_regs;
    end
  end

  // address, data and operand latches
  always_ff @(posedge in_clk) begin
    mem_addr  <= next_mem_addr;
    mem_wdata <= next_mem_wdata;
    ra        <= next_ra;
    rb        <= next_rb;
    imm       <= next_imm;
  end

  // --------------------
  // fetch / decode / exec
  always_comb begin
    next_cycle     = cycle;
    next_sub       = sub;
    next_instr     = instr;
    next_mem_req   = 1'b0;            // read request is a one-cycle pulse
    next_mem_write = mem_write;
    next_mem_addr  = mem_addr;
    next_mem_wdata = mem_wdata;
    next_pc        = pc;
    next_regs      = regs;
    next_ra        = ra;
    next_rb        = rb;
    next_imm       = imm;
    rd_issue       = 1'b0;

    case (cycle)
      FETCH, LOAD_IMM: begin
        if (!sub) begin
          next_mem_addr = pc;         // both read the word at pc
          next_pc       = pc + 8'd1;
          next_mem_req  = 1'b1;
          next_sub      = 1'b1;
        end else if (mem_ack) begin
          next_sub = 1'b0;
          if (cycle == FETCH) begin
            next_instr = mem_rdata;
            next_cycle = DECODE;
          end else begin
            next_imm   = mem_rdata;
            next_cycle = EXEC;
          end
        end
      end

      DECODE: begin
        next_cycle = EXEC;
        if (instr[7]) begin           // two-register form
          next_ra = instr[3:2];
          next_rb = instr[1:0];
        end else begin
          next_ra = instr[1:0];
          if (instr[7:6] == CLS_ONE && instr[IMM_BIT]) begin
            next_cycle = LOAD_IMM;
          end
        end
      end

      EXEC: begin
        next_cycle = FETCH;           // most ops finish here
        if (sub) begin                // second half of ldm, pop, ret
          next_cycle = EXEC;
          if (mem_ack) begin
            next_sub   = 1'b0;
            next_cycle = FETCH;
            if (instr[6]) begin
              next_regs[ra] = mem_rdata;  // ldm, pop
            end else begin
              next_pc = mem_rdata;        // ret
            end
          end
        end else if (instr[7]) begin
          case (alu_op)
            MOV:     next_regs[rb] = alu_result;
            CMP:     next_regs[STATUS_IDX] = alu_flags;
            default: next_regs[ra] = alu_result;
          endcase
        end else if (instr[7:6] == CLS_ONE && instr[IMM_BIT]) begin
          case (instr[4:2])
            OP_LDI: next_regs[ra] = imm;
            OP_LDM: begin
              next_mem_addr = imm;
              rd_issue      = 1'b1;
            end
            OP_STM: begin
              next_mem_addr  = imm;
              next_mem_wdata = regs[ra];
              next_cycle     = WRITE_MEM;
            end
            default: next_cycle = HALT;  // unknown
          endcase
        end else if (instr[7:6] == CLS_ONE) begin
          case (instr[4:2])
            OP_JC: begin
              if (regs[STATUS_IDX][0]) begin
                next_pc = regs[ra];
              end
            end
            OP_JMP:  next_pc = regs[ra];
            OP_JR:   next_pc = pc + regs[ra];  // pc already past the op
            OP_CALL, OP_PUSH: begin
              next_regs[SP_IDX] = regs[SP_IDX] - 8'd1;  // stack grows down
              next_mem_addr     = regs[SP_IDX] - 8'd1;
              next_mem_wdata    = regs[ra];
              next_cycle        = WRITE_MEM;
              if (instr[4:2] == OP_CALL) begin
                next_pc        = regs[ra];
                next_mem_wdata = pc;          // return address
              end
            end
            OP_NOT:  next_regs[ra] = ~regs[ra];
            OP_LNOT: next_regs[ra] = word_t'(regs[ra] == '0);
            OP_POP: begin
              next_regs[SP_IDX] = regs[SP_IDX] + 8'd1;
              next_mem_addr     = regs[SP_IDX];
              rd_issue          = 1'b1;
            end
            default: next_cycle = HALT;
          endcase
        end else begin
          case (instr[5:0])
            OP_HALT: next_cycle = HALT;
            OP_NOP:  next_cycle = FETCH;
            OP_RET: begin
              next_regs[SP_IDX] = regs[SP_IDX] + 8'd1;
              next_mem_addr     = regs[SP_IDX];
              rd_issue          = 1'b1;
            end
            OP_SNE, OP_SGT, OP_SGE, OP_SLT, OP_SLE: begin
              next_regs[STATUS_IDX][0] = regs[STATUS_IDX][flag_sel];
            end
            default: next_cycle = HALT;  // incl. the immediate form
          endcase
        end
        if (rd_issue) begin
          next_mem_req = 1'b1;
          next_sub     = 1'b1;
          next_cycle   = EXEC;        // wait for the read in subcycle 1
        end
      end

      WRITE_MEM: begin
        next_mem_req   = 1'b1;        // held until acknowledged
        next_mem_write = 1'b1;
        next_sub       = 1'b1;
        if (sub && mem_ack) begin
          next_mem_req   = 1'b0;
          next_mem_write = 1'b0;
          next_sub       = 1'b0;
          next_cycle     = FETCH;
        end
      end

      HALT: begin
        next_cycle = HALT;            // only reset leaves
      end

      default: begin
        next_cycle = HALT;
      end
    endcase
  end

  // --------------------
  // checks
  a_write_has_req: assert property (@(posedge in_clk) disable iff (in_rst)
    mem_write |-> mem_req);

  a_halt_sticky: assert property (@(posedge in_clk) disable iff (in_rst)
    cycle == HALT |=> cycle == HALT && !mem_req);

endmodule

//--- hdl/cpu8_alu.sv
// cpu8 two-operand unit
`timescale 1ns/1ps

module cpu8_alu (
  input  cpu8_pkg::alu_op_t op,
  input  cpu8_pkg::word_t   a,       // register aa
  input  cpu8_pkg::word_t   b,       // register bb
  output cpu8_pkg::word_t   result,
  output cpu8_pkg::word_t   flags    // status word for cmp
);
  import cpu8_pkg::*;

  // --------------------
  // compare flags, unsigned
  always_comb begin
    flags          = '0;        // bits 7..6 stay clear
    flags[FLAG_EQ] = (a == b);
    flags[FLAG_NE] = (a != b);
    flags[FLAG_GT] = (a > b);
    flags[FLAG_GE] = (a >= b);
    flags[FLAG_LT] = (a < b);
    flags[FLAG_LE] = (a <= b);
  end

  // --------------------
  // result path
  always_comb begin
    result = a;                 // mov and cmp pass aa
    case (op)
      MOV: begin
        result = a;             // core writes it to bb
      end
      ADD: begin
        result = a + b;
      end
      SUB: begin
        result = a - b;         // wraps
      end
      SHL: begin
        result = a << b;
      end
      SHR: begin
        result = a >> b;        // logical
      end
      CMP: begin
        result = a;             // only flags matter
      end
      AND: begin
        result = a & b;
      end
      OR: begin
        result = a | b;
      end
      default: begin
        result = a;
      end
    endcase
  end

endmodule

//--- hdl/cpu8_pkg.sv
// cpu8 shared definitions
package cpu8_pkg;

  typedef logic [7:0] word_t;     // data word
  typedef logic [7:0] addr_t;     // memory address
  typedef logic [1:0] reg_idx_t;  // one of four registers

  // --------------------
  // special registers
  localparam reg_idx_t SP_IDX     = 2'd0;  // stack pointer
  localparam reg_idx_t STATUS_IDX = 2'd3;  // bit 0 is the condition

  // compare flag positions in the status word
  localparam int FLAG_EQ = 0;
  localparam int FLAG_NE = 1;
  localparam int FLAG_GT = 2;
  localparam int FLAG_GE = 3;
  localparam int FLAG_LT = 4;
  localparam int FLAG_LE = 5;

  // --------------------
  // opcode fields
  localparam int         IMM_BIT = 5;      // immediate word follows
  localparam logic [1:0] CLS_ONE = 2'b01;  // one-register class, 2-reg has bit 7 set

  // one-register sub-ops, bits 4..2
  localparam logic [2:0] OP_LDI  = 3'b000;  // with immediate
  localparam logic [2:0] OP_LDM  = 3'b001;
  localparam logic [2:0] OP_STM  = 3'b010;
  localparam logic [2:0] OP_JC   = 3'b000;  // without immediate
  localparam logic [2:0] OP_JMP  = 3'b001;
  localparam logic [2:0] OP_JR   = 3'b010;
  localparam logic [2:0] OP_CALL = 3'b011;
  localparam logic [2:0] OP_NOT  = 3'b100;
  localparam logic [2:0] OP_LNOT = 3'b101;
  localparam logic [2:0] OP_PUSH = 3'b110;
  localparam logic [2:0] OP_POP  = 3'b111;

  // zero-register ops, bits 5..0 with the immediate bit clear
  localparam logic [5:0] OP_HALT = 6'd0;
  localparam logic [5:0] OP_NOP  = 6'd1;
  localparam logic [5:0] OP_RET  = 6'd2;
  localparam logic [5:0] OP_SNE  = 6'd4;
  localparam logic [5:0] OP_SGT  = 6'd5;
  localparam logic [5:0] OP_SGE  = 6'd6;
  localparam logic [5:0] OP_SLT  = 6'd7;
  localparam logic [5:0] OP_SLE  = 6'd8;

  typedef enum logic [2:0] {FETCH, DECODE, LOAD_IMM, EXEC, WRITE_MEM, HALT} cycle_t;
  typedef enum logic [2:0] {MOV, ADD, SUB, SHL, SHR, CMP, AND, OR} alu_op_t;

endpackage
